// File: common/dvb_pkg.sv
`default_nettype none

package dvb_pkg;

	// one complex constellation point
	typedef struct packed {
		logic signed [15:0] re;
		logic signed [15:0] im;
	} sym_t;

	typedef enum logic {
		MOD_QPSK = 1'b0, // 2 bits per symbol
		MOD_BPSK = 1'b1  // 1 bit per symbol
	} mod_mode_e;

	// constellation amplitudes
	localparam logic signed [15:0] AMP_QPSK = 16'sd23170; // about 0.707 full scale
	localparam logic signed [15:0] AMP_BPSK = 16'sd32767;

	// register word addresses
	localparam int unsigned REG_MOD_MODE   = 0;
	localparam int unsigned REG_FREQ_INV   = 1;
	localparam int unsigned REG_BAUD_DIV   = 2;
	localparam int unsigned REG_SYM_COUNT  = 3; // read only
	localparam int unsigned REG_DROP_COUNT = 4; // read only

	// reset values of the writable registers
	localparam int unsigned RST_MOD_MODE = 0;
	localparam int unsigned RST_FREQ_INV = 0;
	localparam int unsigned RST_BAUD_DIV = 3;

	// upper half of an unmapped read, address goes in the lower half
	localparam logic [15:0] MISS_TAG = 16'hE000;

endpackage

`default_nettype wire

// File: common/symbol_if.sv
`timescale 1ns/100ps
`default_nettype none

interface symbol_if #(
	parameter type T = dvb_pkg::sym_t
);
	logic push;      // one-cycle strobe
	T     push_data;
	logic full;
	logic pop;       // one-cycle strobe, only while not empty
	T     pop_data;  // valid the cycle after pop
	logic empty;

	modport producer (output push, output push_data, input full);
	modport fifo (
		input  push,
		input  push_data,
		input  pop,
		output full,
		output empty,
		output pop_data
	);
	modport consumer (output pop, input empty, input pop_data);

endinterface

`default_nettype wire

// File: regs/dvb_cfg_regs.sv
`timescale 1ns/100ps
`default_nettype none

module dvb_cfg_regs #(
	parameter int DATA_WIDTH = 32,
	parameter int ADDR_BITS  = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      wen,
	input  logic [ADDR_BITS-1:0]      waddr,
	input  logic [DATA_WIDTH-1:0]     wdata,
	input  logic [DATA_WIDTH/8-1:0]   wstrb,
	input  logic                      ren,
	input  logic [ADDR_BITS-1:0]      raddr,
	output logic [DATA_WIDTH-1:0]     rdata,
	input  logic [31:0]               sym_count,
	input  logic [31:0]               drop_count,
	output dvb_pkg::mod_mode_e        mod_mode,
	output logic                      freq_inv,
	output logic [15:0]               baud_div
);
	import dvb_pkg::*;

	localparam int LANES = DATA_WIDTH / 8;

	// write staging stage
	logic                  wr_pend;
	logic [ADDR_BITS-1:0]  wr_addr;
	logic [DATA_WIDTH-1:0] wr_data;
	logic [LANES-1:0]      wr_strb;

	logic [DATA_WIDTH-1:0] mod_mode_reg;
	logic [DATA_WIDTH-1:0] freq_inv_reg;
	logic [DATA_WIDTH-1:0] baud_div_reg;

	// strobed lanes take the new byte, the others keep the current one
	function automatic logic [DATA_WIDTH-1:0] merge_lanes(
		input logic [DATA_WIDTH-1:0] cur,
		input logic [DATA_WIDTH-1:0] upd,
		input logic [LANES-1:0]      strb
	);
		logic [DATA_WIDTH-1:0] res;
		res = cur;
		for (int i = 0; i < LANES; i++) begin
			if (strb[i])
				res[8*i +: 8] = upd[8*i +: 8];
		end
		return res;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n)
			wr_pend <= 1'b0;
		else
			wr_pend <= wen;
	end

	always_ff @(posedge clk) begin
		if (wen) begin
			wr_addr <= waddr;
			wr_data <= wdata;
			wr_strb <= wstrb;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mod_mode_reg <= DATA_WIDTH'(RST_MOD_MODE);
			freq_inv_reg <= DATA_WIDTH'(RST_FREQ_INV);
			baud_div_reg <= DATA_WIDTH'(RST_BAUD_DIV);
		end else if (wr_pend) begin
			case (wr_addr)
				REG_MOD_MODE: mod_mode_reg <= merge_lanes(mod_mode_reg, wr_data, wr_strb);
				REG_FREQ_INV: freq_inv_reg <= merge_lanes(freq_inv_reg, wr_data, wr_strb);
				REG_BAUD_DIV: baud_div_reg <= merge_lanes(baud_div_reg, wr_data, wr_strb);
				default: ; // counts are read only
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (ren) begin
			case (raddr)
				REG_MOD_MODE:   rdata <= mod_mode_reg;
				REG_FREQ_INV:   rdata <= freq_inv_reg;
				REG_BAUD_DIV:   rdata <= baud_div_reg;
				REG_SYM_COUNT:  rdata <= DATA_WIDTH'(sym_count);
				REG_DROP_COUNT: rdata <= DATA_WIDTH'(drop_count);
				default:        rdata <= DATA_WIDTH'({MISS_TAG, 16'(raddr)});
			endcase
		end
	end

	assign mod_mode = mod_mode_e'(mod_mode_reg[0]);
	assign freq_inv = freq_inv_reg[0];
	assign baud_div = baud_div_reg[15:0];

endmodule

`default_nettype wire

// File: logic/symbol_mapper.sv
`timescale 1ns/100ps
`default_nettype none

module symbol_mapper (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               ts_valid,
	input  logic [7:0]         ts_data,
	input  dvb_pkg::mod_mode_e mod_mode,
	symbol_if.producer         sym,
	output logic [31:0]        drop_count
);
	import dvb_pkg::*;

	logic       busy;
	logic [3:0] syms_left; // symbols still to push for this byte
	logic [7:0] shift_q;   // msb goes out first
	mod_mode_e  mode_q;    // mode sampled at accept
	logic       busy_drop;
	logic       full_drop;

	assign busy_drop = ts_valid && busy;
	assign full_drop = busy && sym.full;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			syms_left  <= '0;
			drop_count <= '0;
		end else begin
			drop_count <= drop_count + 32'(busy_drop) + 32'(full_drop);
			if (!busy) begin
				if (ts_valid) begin
					busy      <= 1'b1;
					syms_left <= (mod_mode == MOD_QPSK) ? 4'd4 : 4'd8;
				end
			end else if (sym.full) begin
				busy <= 1'b0; // rest of the byte is discarded
			end else begin
				syms_left <= syms_left - 4'd1;
				if (syms_left == 4'd1)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && ts_valid) begin
			shift_q <= ts_data;
			mode_q  <= mod_mode;
		end else if (busy) begin
			shift_q <= (mode_q == MOD_QPSK) ? {shift_q[5:0], 2'b00} : {shift_q[6:0], 1'b0};
		end
	end

	assign sym.push = busy;

	always_comb begin
		if (mode_q == MOD_QPSK) begin
			sym.push_data.re = shift_q[7] ? -AMP_QPSK : AMP_QPSK;
			sym.push_data.im = shift_q[6] ? -AMP_QPSK : AMP_QPSK;
		end else begin
			sym.push_data.re = shift_q[7] ? -AMP_BPSK : AMP_BPSK;
			sym.push_data.im = '0;
		end
	end

endmodule

`default_nettype wire

// File: logic/symbol_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module symbol_fifo #(
	parameter type T          = dvb_pkg::sym_t,
	parameter int  FIFO_DEPTH = 16
) (
	input  logic   clk,
	input  logic   rst_n,
	symbol_if.fifo q
);
	localparam int AW = $clog2(FIFO_DEPTH);

	T             mem [FIFO_DEPTH];
	logic [AW:0]  wr_ptr; // extra msb tells full from empty
	logic [AW:0]  rd_ptr;
	logic         do_wr;
	logic         do_rd;

	assign q.empty = (wr_ptr == rd_ptr);
	assign q.full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign do_wr = q.push && !q.full;  // push into a full fifo is lost
	assign do_rd = q.pop && !q.empty;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr[AW-1:0]] <= q.push_data;
	end

	// registered read, data shows up the cycle after pop
	always_ff @(posedge clk) begin
		if (do_rd)
			q.pop_data <= mem[rd_ptr[AW-1:0]];
	end

endmodule

`default_nettype wire

// File: logic/symbol_rate_out.sv
`timescale 1ns/100ps
`default_nettype none

module symbol_rate_out (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [15:0]        baud_div,
	input  logic               freq_inv,
	symbol_if.consumer         sym,
	output logic               sym_oe,
	output logic signed [15:0] sym_re,
	output logic signed [15:0] sym_im,
	output logic [31:0]        sym_count
);
	logic [15:0] div_cnt;
	logic        baud_tick;

	// tick every baud_div+1 cycles
	// >= covers baud_div being lowered mid count
	assign baud_tick = (div_cnt >= baud_div);

	always_ff @(posedge clk) begin
		if (!rst_n)
			div_cnt <= '0;
		else if (baud_tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 16'd1;
	end

	assign sym.pop = baud_tick && !sym.empty;

	// oe lines up with pop_data
	always_ff @(posedge clk) begin
		if (!rst_n)
			sym_oe <= 1'b0;
		else
			sym_oe <= sym.pop;
	end

	// spectrum inversion swaps i and q
	always_comb begin
		if (freq_inv) begin
			sym_re = sym.pop_data.im;
			sym_im = sym.pop_data.re;
		end else begin
			sym_re = sym.pop_data.re;
			sym_im = sym.pop_data.im;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			sym_count <= '0;
		else if (sym_oe)
			sym_count <= sym_count + 32'd1;
	end

endmodule

`default_nettype wire

// File: logic/dvb_mod_top.sv
`timescale 1ns/100ps
`default_nettype none

module dvb_mod_top #(
	parameter int DATA_WIDTH = 32, // multiple of 8
	parameter int ADDR_BITS  = 4,
	parameter int FIFO_DEPTH = 16  // power of two
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    wen,
	input  logic [ADDR_BITS-1:0]    waddr,
	input  logic [DATA_WIDTH-1:0]   wdata,
	input  logic [DATA_WIDTH/8-1:0] wstrb,
	input  logic                    ren,
	input  logic [ADDR_BITS-1:0]    raddr,
	output logic [DATA_WIDTH-1:0]   rdata,
	input  logic                    ts_valid,
	input  logic [7:0]              ts_data,
	output logic                    sym_oe,
	output logic signed [15:0]      sym_re,
	output logic signed [15:0]      sym_im
);
	import dvb_pkg::*;

	mod_mode_e   mod_mode;
	logic        freq_inv;
	logic [15:0] baud_div;
	logic [31:0] sym_count;
	logic [31:0] drop_count;

	symbol_if #(.T(sym_t)) sym_bus ();

	dvb_cfg_regs #(
		.DATA_WIDTH (DATA_WIDTH),
		.ADDR_BITS  (ADDR_BITS)
	) u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.wen        (wen),
		.waddr      (waddr),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.ren        (ren),
		.raddr      (raddr),
		.rdata      (rdata),
		.sym_count  (sym_count),
		.drop_count (drop_count),
		.mod_mode   (mod_mode),
		.freq_inv   (freq_inv),
		.baud_div   (baud_div)
	);

	symbol_mapper u_mapper (
		.clk        (clk),
		.rst_n      (rst_n),
		.ts_valid   (ts_valid),
		.ts_data    (ts_data),
		.mod_mode   (mod_mode),
		.sym        (sym_bus.producer),
		.drop_count (drop_count)
	);

	symbol_fifo #(
		.T          (sym_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.q     (sym_bus.fifo)
	);

	symbol_rate_out u_rate_out (
		.clk       (clk),
		.rst_n     (rst_n),
		.baud_div  (baud_div),
		.freq_inv  (freq_inv),
		.sym       (sym_bus.consumer),
		.sym_oe    (sym_oe),
		.sym_re    (sym_re),
		.sym_im    (sym_im),
		.sym_count (sym_count)
	);

endmodule

`default_nettype wire

// File: test/dvb_mod_props.sv
`timescale 1ns/100ps
`default_nettype none

module dvb_mod_props (
	input logic clk,
	input logic rst_n,
	input logic push,
	input logic full,
	input logic pop,
	input logic empty,
	input logic sym_oe
);
	// a full fifo with no pop stays full, so no push got in
	property no_push_when_full;
		@(posedge clk) disable iff (!rst_n) (full && !pop) |=> full;
	endproperty

	property no_pop_when_empty;
		@(posedge clk) disable iff (!rst_n) pop |-> !empty;
	endproperty

	property oe_after_pop;
		@(posedge clk) disable iff (!rst_n) pop |=> sym_oe;
	endproperty

	property oe_needs_pop;
		@(posedge clk) disable iff (!rst_n) sym_oe |-> $past(pop);
	endproperty

	assert property (no_push_when_full) else $error("push accepted into a full FIFO");
	assert property (no_pop_when_empty) else $error("pop issued while FIFO empty");
	assert property (oe_after_pop) else $error("sym_oe missing one cycle after pop");
	assert property (oe_needs_pop) else $error("sym_oe without a pop one cycle before");

endmodule

bind dvb_mod_top dvb_mod_props u_props (
	.clk    (clk),
	.rst_n  (rst_n),
	.push   (sym_bus.push),
	.full   (sym_bus.full),
	.pop    (sym_bus.pop),
	.empty  (sym_bus.empty),
	.sym_oe (sym_oe)
);

`default_nettype wire

// File: test/tb_dvb_mod.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dvb_mod;
	import dvb_pkg::*;

	typedef enum logic [2:0] {
		OP_WR,    // register write
		OP_RD,    // read and compare with the row's expected value
		OP_SEND,  // one random byte, then 40 idle cycles
		OP_BUSY,  // two bytes back to back, second one is dropped
		OP_CNT,   // drain, then read a live count
		OP_SPACE  // one byte, pulse spacing checked at baud_div 7
	} op_e;

	typedef struct {
		op_e         op;
		logic [3:0]  addr;
		logic [31:0] data;
		logic [3:0]  strb;
		logic [31:0] want;
	} row_t;

	logic               clk;
	logic               rst_n;
	logic               wen;
	logic [3:0]         waddr;
	logic [31:0]        wdata;
	logic [3:0]         wstrb;
	logic               ren;
	logic [3:0]         raddr;
	logic [31:0]        rdata;
	logic               ts_valid;
	logic [7:0]         ts_data;
	logic               sym_oe;
	logic signed [15:0] sym_re;
	logic signed [15:0] sym_im;

	row_t        rows[$];
	sym_t        exp_q[$]; // model output, oldest first
	logic [31:0] rand_state = 32'hbf873775;
	logic        mode_sh;  // 1 means BPSK
	logic        inv_sh;
	int          drops_exp;
	int          pulses;
	int          checks;
	int          errors;
	int          cycle;
	int          limit;
	logic        gap_check;
	logic        have_prev;
	int          prev_cycle;
	int          gaps;

	dvb_mod_top #(
		.DATA_WIDTH (32),
		.ADDR_BITS  (4),
		.FIFO_DEPTH (16)
	) DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.wen      (wen),
		.waddr    (waddr),
		.wdata    (wdata),
		.wstrb    (wstrb),
		.ren      (ren),
		.raddr    (raddr),
		.rdata    (rdata),
		.ts_valid (ts_valid),
		.ts_data  (ts_data),
		.sym_oe   (sym_oe),
		.sym_re   (sym_re),
		.sym_im   (sym_im)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [7:0] lcg_next();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state[23:16];
	endfunction

	task automatic add_row(input op_e op, input int addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [31:0] want);
		row_t r;
		r.op = op;
		r.addr = 4'(addr);
		r.data = data;
		r.strb = strb;
		r.want = want;
		rows.push_back(r);
	endtask

	// expected symbols of one byte, msb first
	task automatic queue_symbols(input logic [7:0] b);
		sym_t               s;
		logic signed [15:0] t;
		int                 n;
		n = mode_sh ? 8 : 4;
		for (int k = 0; k < n; k++) begin
			if (mode_sh) begin
				s.re = b[7-k] ? -AMP_BPSK : AMP_BPSK;
				s.im = '0;
			end else begin
				s.re = b[7-2*k] ? -AMP_QPSK : AMP_QPSK;
				s.im = b[6-2*k] ? -AMP_QPSK : AMP_QPSK;
			end
			if (inv_sh) begin // spectrum inversion
				t = s.re;
				s.re = s.im;
				s.im = t;
			end
			exp_q.push_back(s);
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk); // let the counters settle
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		@(posedge clk);
		wen <= 1'b1;
		waddr <= addr;
		wdata <= data;
		wstrb <= strb;
		@(posedge clk);
		wen <= 1'b0;
		repeat (2) @(posedge clk); // staged write lands
		if (addr == 4'(REG_MOD_MODE) && strb[0])
			mode_sh = data[0];
		if (addr == 4'(REG_FREQ_INV) && strb[0])
			inv_sh = data[0];
	endtask

	task automatic read_check(input logic [3:0] addr, input logic [31:0] want);
		logic [31:0] got;
		@(posedge clk);
		ren <= 1'b1;
		raddr <= addr;
		@(posedge clk);
		ren <= 1'b0;
		@(posedge clk);
		got = rdata;
		checks++;
		if (got !== want) begin
			$display("Fail rdata: addr 0x%0h got 0x%08h expected 0x%08h", addr, got, want);
			errors++;
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		ts_valid <= 1'b1;
		ts_data <= b;
		@(posedge clk);
		ts_valid <= 1'b0;
	endtask

	task automatic send_random();
		logic [7:0] b;
		b = lcg_next();
		queue_symbols(b);
		send_byte(b);
		repeat (40) @(posedge clk); // gap before the next byte
	endtask

	task automatic send_pair();
		logic [7:0] first;
		logic [7:0] second;
		first = lcg_next();
		second = lcg_next();
		queue_symbols(first);
		@(posedge clk);
		ts_valid <= 1'b1;
		ts_data <= first;
		@(posedge clk);
		ts_data <= second; // mapper is busy with the first byte
		@(posedge clk);
		ts_valid <= 1'b0;
		drops_exp++;
		wait_drain();
	endtask

	task automatic check_spacing();
		logic [7:0] b;
		b = lcg_next();
		gap_check = 1'b1;
		have_prev = 1'b0;
		gaps = 0;
		queue_symbols(b);
		send_byte(b);
		wait_drain();
		gap_check = 1'b0;
		checks++;
		if (gaps != 4) begin
			$display("only %0d of 4 symbols were timed at baud_div 7", gaps);
			errors++;
		end
	endtask

	// compare each output symbol with the model
	always @(posedge clk) begin
		sym_t want;
		if (rst_n && sym_oe) begin
			pulses++;
			if (exp_q.size() == 0) begin
				$display("symbol appeared on the output with none expected");
				errors++;
			end else begin
				want = exp_q.pop_front();
				checks++;
				if (sym_re !== want.re) begin
					$display("Fail sym_re: got 0x%04h expected 0x%04h", sym_re, want.re);
					errors++;
				end
				if (sym_im !== want.im) begin
					$display("Fail sym_im: got 0x%04h expected 0x%04h", sym_im, want.im);
					errors++;
				end
			end
			if (gap_check) begin
				if (have_prev && cycle - prev_cycle != 8) begin
					$display("Fail sym_oe spacing: got 0x%0h expected 0x8", cycle - prev_cycle);
					errors++;
				end
				gaps++;
				have_prev = 1'b1;
				prev_cycle = cycle;
			end
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (limit != 0 && cycle >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		wen = 1'b0;
		waddr = '0;
		wdata = '0;
		wstrb = '0;
		ren = 1'b0;
		raddr = '0;
		ts_valid = 1'b0;
		ts_data = '0;
		mode_sh = 1'b0;
		inv_sh = 1'b0;
		drops_exp = 0;
		pulses = 0;
		checks = 0;
		errors = 0;
		cycle = 0;
		limit = 0;
		gap_check = 1'b0;
		have_prev = 1'b0;
		prev_cycle = 0;
		gaps = 0;

		// reset values
		add_row(OP_RD, REG_MOD_MODE, 0, 4'h0, 32'h0);
		add_row(OP_RD, REG_FREQ_INV, 0, 4'h0, 32'h0);
		add_row(OP_RD, REG_BAUD_DIV, 0, 4'h0, 32'h3);
		add_row(OP_RD, REG_SYM_COUNT, 0, 4'h0, 32'h0);
		add_row(OP_RD, REG_DROP_COUNT, 0, 4'h0, 32'h0);
		// byte lanes, read-only count, unmapped reads
		add_row(OP_WR, REG_BAUD_DIV, 32'hAABBCC05, 4'b0101, 0);
		add_row(OP_RD, REG_BAUD_DIV, 0, 4'h0, 32'h00BB0005);
		add_row(OP_WR, REG_BAUD_DIV, 32'h11223307, 4'b1000, 0);
		add_row(OP_RD, REG_BAUD_DIV, 0, 4'h0, 32'h11BB0005);
		add_row(OP_WR, REG_BAUD_DIV, 32'h00000003, 4'b1111, 0);
		add_row(OP_RD, REG_BAUD_DIV, 0, 4'h0, 32'h00000003);
		add_row(OP_WR, REG_FREQ_INV, 32'hFFFFFF00, 4'b0110, 0);
		add_row(OP_RD, REG_FREQ_INV, 0, 4'h0, 32'h00FFFF00);
		add_row(OP_WR, REG_FREQ_INV, 32'h0, 4'b1111, 0);
		add_row(OP_WR, REG_SYM_COUNT, 32'hDEADBEEF, 4'b1111, 0);
		add_row(OP_RD, REG_SYM_COUNT, 0, 4'h0, 32'h0);
		add_row(OP_RD, 5, 0, 4'h0, 32'hE0000005);
		add_row(OP_RD, 15, 0, 4'h0, 32'hE000000F);
		// QPSK
		repeat (4) add_row(OP_SEND, 0, 0, 4'h0, 0);
		add_row(OP_CNT, REG_SYM_COUNT, 0, 4'h0, 0);
		// BPSK with inversion
		add_row(OP_WR, REG_MOD_MODE, 32'h1, 4'b0001, 0);
		add_row(OP_RD, REG_MOD_MODE, 0, 4'h0, 32'h1);
		add_row(OP_WR, REG_FREQ_INV, 32'h1, 4'b0001, 0);
		repeat (3) add_row(OP_SEND, 0, 0, 4'h0, 0);
		add_row(OP_WR, REG_FREQ_INV, 32'h0, 4'b0001, 0);
		add_row(OP_WR, REG_MOD_MODE, 32'h0, 4'b0001, 0);
		// busy drop
		add_row(OP_BUSY, 0, 0, 4'h0, 0);
		add_row(OP_CNT, REG_DROP_COUNT, 0, 4'h0, 0);
		add_row(OP_CNT, REG_SYM_COUNT, 0, 4'h0, 0);
		// baud spacing
		add_row(OP_WR, REG_BAUD_DIV, 32'h7, 4'b0001, 0);
		add_row(OP_SPACE, 0, 0, 4'h0, 0);
		add_row(OP_WR, REG_BAUD_DIV, 32'h3, 4'b1111, 0);
		add_row(OP_CNT, REG_SYM_COUNT, 0, 4'h0, 0);
		add_row(OP_CNT, REG_DROP_COUNT, 0, 4'h0, 0);
		limit = rows.size() * 64 + 200;

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		foreach (rows[i]) begin
			case (rows[i].op)
				OP_WR: begin
					wait_drain(); // mode changes only between bytes
					write_reg(rows[i].addr, rows[i].data, rows[i].strb);
				end
				OP_RD: read_check(rows[i].addr, rows[i].want);
				OP_SEND: send_random();
				OP_BUSY: send_pair();
				OP_CNT: begin
					wait_drain();
					if (rows[i].addr == 4'(REG_SYM_COUNT))
						read_check(rows[i].addr, 32'(pulses));
					else
						read_check(rows[i].addr, 32'(drops_exp));
				end
				OP_SPACE: check_spacing();
				default: ;
			endcase
			$display("test %0d %s finished, errors so far %0d", i, rows[i].op.name(), errors);
		end

		wait_drain();
		$display("tests %0d, checks %0d, errors %0d", rows.size(), checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: Makefile
TOOL   = verilator
TOP    = tb_dvb_mod
FLIST  = tb.f
FLAGS  = --binary --assert -Wno-fatal --top-module $(TOP)
OBJDIR = obj_dir
LOG    = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --Mdir $(OBJDIR) -f $(FLIST)

run: compile
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tb.f
common/dvb_pkg.sv
common/symbol_if.sv
regs/dvb_cfg_regs.sv
logic/symbol_mapper.sv
logic/symbol_fifo.sv
logic/symbol_rate_out.sv
logic/dvb_mod_top.sv
test/dvb_mod_props.sv
test/tb_dvb_mod.sv
